// ==== verif/pipe_trace.txt ====
# I <instruction hex> <inReady low cycles> <test name>
# E <destination register> <retired value hex>
I C185 0 lbi_r1_neg
E 1 FF85
I C234 0 lbi_r2_pos
E 2 0034
I 0800 0 nop_a
I 407D 0 addi_r3_neg
E 3 FFFD
I 529F 0 xori_r4_zext
E 4 002B
I 59AF 0 andni_r5
E 5 FF80
I 4ADE 0 subi_r6_neg
E 6 FFCA
I 913C 0 slbi_r1
E 1 853C
I DB9C 0 add_r7
E 7 0028
I DDC9 0 sub_r2
E 2 004A
I DA2E 2 xor_r3_b2b
E 3 8576
I DF73 2 andn_r4_b2b
E 4 0008
I 40A1 0 addi_r5_indep
E 5 0001
I 44C2 1 addi_r6_gap1
E 6 000A
I FFFF 0 unknown_op
I 56F0 1 xori_r7_gap1
E 7 001A
I 95A0 0 slbi_r5
E 5 01A0
I DAA5 2 sub_r1_b2b
E 1 0156
I 0800 0 nop_b
I 415F 1 addi_r2_gap1
E 2 0155
I C07F 0 lbi_r0
E 0 007F

// ==== tb.f ====
+incdir+verilog
verilog/pipePkg.sv
verilog/stageIf.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/executeStage.sv
verilog/pipeCore.sv
verif/pipeCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pipeCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module pipeCoreTb -o simPipeCore
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simPipeCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
exit 0

// ==== verif/pipeCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module pipeCoreTb;

	logic                    clk;
	logic                    rstN;
	logic                    inValid;
	logic                    inReady;
	logic [`PIPE_DATA_W-1:0] inInst;
	logic                    wbValid;
	logic [`PIPE_SEL_W-1:0]  wbReg;
	logic [`PIPE_DATA_W-1:0] wbData;

	// Trace contents indexed by instruction
	logic [`PIPE_DATA_W-1:0] words [64];
	logic [8*24-1:0]         names [64];
	int                      stallExp [64];
	int                      stallSeen [64];
	bit                      hasExp [64];
	logic [`PIPE_SEL_W-1:0]  expReg [64];
	logic [`PIPE_DATA_W-1:0] expVal [64];
	bit                      testBad [64];

	int nTests = 0;
	int nExp = 0;
	int retired = 0;
	int retPtr = 0;
	int reportIdx = 0;
	int passCnt = 0;
	int failCnt = 0;
	int otherErrs = 0;
	int driveIdx = 0;
	int heldIdx = -1;
	bit willAccept = 0;
	int cycles = 0;
	int limit = 1000;
	int seed = 76345;

	pipeCore uut (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.inReady (inReady),
		.inInst  (inInst),
		.wbValid (wbValid),
		.wbReg   (wbReg),
		.wbData  (wbData)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	task automatic readTrace();
		int              fd;
		int              code;
		int              num;
		logic [7:0]      tag;
		logic [8*96-1:0] rest;
		logic [15:0]     val;
		fd = $fopen("verif/pipe_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file verif/pipe_trace.txt");
			otherErrs++;
		end else begin
			code = $fscanf(fd, "%s", tag);
			while (code == 1) begin
				if (tag == "#") begin
					code = $fgets(rest, fd);
				end else if (tag == "I") begin
					code = $fscanf(fd, "%h %d %s", val, num, names[nTests]);
					words[nTests] = val;
					stallExp[nTests] = num;
					stallSeen[nTests] = 0;
					hasExp[nTests] = 1'b0;
					testBad[nTests] = 1'b0;
					nTests++;
				end else if (tag == "E") begin
					code = $fscanf(fd, "%d %h", num, val);
					// Expect line belongs to the instruction above it
					hasExp[nTests-1] = 1'b1;
					expReg[nTests-1] = num[2:0];
					expVal[nTests-1] = val;
					nExp++;
				end
				code = $fscanf(fd, "%s", tag);
			end
			$fclose(fd);
		end
	endtask

	// Tests up to last have left the pipeline
	task automatic reportUpTo(input int last);
		while (reportIdx <= last) begin
			assert (stallSeen[reportIdx] == stallExp[reportIdx]) else begin
				$display("MISMATCH %0s stall cycles expected %0d actual %0d",
					names[reportIdx], stallExp[reportIdx], stallSeen[reportIdx]);
				testBad[reportIdx] = 1'b1;
			end
			if (testBad[reportIdx]) begin
				$display("Test %0s failed", names[reportIdx]);
				failCnt++;
			end else begin
				$display("Test %0s ok", names[reportIdx]);
				passCnt++;
			end
			reportIdx++;
		end
	endtask

	task automatic checkRetire();
		while (retPtr < nTests && !hasExp[retPtr]) begin
			retPtr++;
		end
		if (retPtr >= nTests) begin
			assert (0) else begin
				$display("Register write of r%0d retired with no instruction left to expect it",
					wbReg);
				otherErrs++;
			end
		end else begin
			assert (wbReg == expReg[retPtr] && wbData == expVal[retPtr]) else begin
				$display("MISMATCH %0s expected r%0d=%h actual r%0d=%h", names[retPtr],
					expReg[retPtr], expVal[retPtr], wbReg, wbData);
				testBad[retPtr] = 1'b1;
			end
			retired++;
			reportUpTo(retPtr);
			retPtr++;
		end
	endtask

	// Sample mid-cycle once inputs and flops have settled
	always @(negedge clk) begin
		if (rstN) begin
			if (!inReady && heldIdx >= 0) begin
				stallSeen[heldIdx]++;
			end
			willAccept = inValid && inReady;
			if (willAccept) begin
				heldIdx = driveIdx;
			end
			if (wbValid) begin
				checkRetire();
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout after %0d cycles with %0d of %0d retirements seen",
				cycles, retired, nExp);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		int gap;
		rstN = 1'b0;
		inValid = 1'b0;
		inInst = '0;
		readTrace();
		limit = 4 * nTests + 16 + 20;
		repeat (16) @(posedge clk);
		#5 rstN = 1'b1;
		for (int k = 0; k < nTests; k++) begin
			// Idle gaps only where no stall count can shift
			gap = 0;
			if (stallExp[k] == 0 && (k + 1 >= nTests || stallExp[k+1] == 0)) begin
				gap = $random(seed) & 1;
			end
			inValid = 1'b0;
			repeat (gap) begin
				@(posedge clk);
				#5;
			end
			driveIdx = k;
			inValid = 1'b1;
			inInst = words[k];
			@(posedge clk);
			while (!willAccept) begin
				@(posedge clk);
			end
			#5;
		end
		inValid = 1'b0;
		inInst = '0;
		while (retired < nExp) begin
			@(posedge clk);
		end
		// Room for any stray retirement
		repeat (4) @(posedge clk);
		reportUpTo(nTests - 1);
		$display("Summary: %0d tests passed, %0d failed, %0d other errors",
			passCnt, failCnt, otherErrs);
		if (failCnt == 0 && otherErrs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/pipeCore.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module pipeCore (
	input  wire logic                    clk,
	input  wire logic                    rstN,
	input  wire logic                    inValid,
	output logic                         inReady,
	input  wire logic [`PIPE_DATA_W-1:0] inInst,
	output logic                         wbValid,
	output logic [`PIPE_SEL_W-1:0]       wbReg,
	output logic [`PIPE_DATA_W-1:0]      wbData
);

	logic                    stall;
	logic                    idValid;
	pipePkg::instWord_t      idInst;
	logic [`PIPE_SEL_W-1:0]  rdSel1;
	logic [`PIPE_SEL_W-1:0]  rdSel2;
	logic [`PIPE_DATA_W-1:0] rdData1;
	logic [`PIPE_DATA_W-1:0] rdData2;

	decodeExecIf decExec ();
	execWbIf     execWb ();

	fetchStage fetch (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.inReady (inReady),
		.inInst  (inInst),
		.stall   (stall),
		.idValid (idValid),
		.idInst  (idInst)
	);

	decodeStage decode (
		.clk      (clk),
		.rstN     (rstN),
		.idValid  (idValid),
		.idInst   (idInst),
		.stall    (stall),
		.rdSel1   (rdSel1),
		.rdSel2   (rdSel2),
		.rdData1  (rdData1),
		.rdData2  (rdData2),
		.toExec   (decExec.source),
		.fromExec (execWb.hazard)
	);

	// Written from the execute output register
	regFile regs (
		.clk     (clk),
		.rstN    (rstN),
		.rdSel1  (rdSel1),
		.rdSel2  (rdSel2),
		.rdData1 (rdData1),
		.rdData2 (rdData2),
		.wrEn    (wbValid),
		.wrSel   (wbReg),
		.wrData  (wbData)
	);

	executeStage execute (
		.clk     (clk),
		.rstN    (rstN),
		.fromDec (decExec.sink),
		.toDec   (execWb.driver),
		.wbValid (wbValid),
		.wbReg   (wbReg),
		.wbData  (wbData)
	);

endmodule

`default_nettype wire

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module executeStage (
	input  wire logic               clk,
	input  wire logic               rstN,
	decodeExecIf.sink               fromDec,
	execWbIf.driver                 toDec,
	output logic                    wbValid,
	output logic [`PIPE_SEL_W-1:0]  wbReg,
	output logic [`PIPE_DATA_W-1:0] wbData
);

	logic [`PIPE_DATA_W-1:0] aluRes;
	logic                    validQ;
	logic                    regWriteQ;
	logic [`PIPE_SEL_W-1:0]  destQ;
	logic [`PIPE_DATA_W-1:0] resQ;

	always_comb begin
		case (fromDec.aluOp)
			pipePkg::ALU_ADD:   aluRes = fromDec.opA + fromDec.opB;
			pipePkg::ALU_SUBR:  aluRes = fromDec.opB - fromDec.opA;
			pipePkg::ALU_XOR:   aluRes = fromDec.opA ^ fromDec.opB;
			pipePkg::ALU_ANDN:  aluRes = fromDec.opA & ~fromDec.opB;
			pipePkg::ALU_PASSB: aluRes = fromDec.opB;
			pipePkg::ALU_SHOR:  aluRes = {fromDec.opA[7:0], 8'h00} | fromDec.opB;
			default:            aluRes = '0;
		endcase
	end

	// Output register, one cycle of writeback
	always_ff @(posedge clk) begin
		if (!rstN) begin
			validQ    <= 1'b0;
			regWriteQ <= 1'b0;
		end else begin
			validQ    <= fromDec.valid;
			regWriteQ <= fromDec.valid && fromDec.regWrite;
		end
	end

	always_ff @(posedge clk) begin
		destQ <= fromDec.dest;
		resQ  <= aluRes;
	end

	assign wbValid = validQ && regWriteQ;
	assign wbReg   = destQ;
	assign wbData  = resQ;

	// Hazard view for decode
	assign toDec.exValid    = fromDec.valid;
	assign toDec.exDest     = fromDec.dest;
	assign toDec.exRegWrite = fromDec.regWrite;
	assign toDec.wbValid    = wbValid;
	assign toDec.wbDest     = destQ;

	wbRegKnown: assert property (@(posedge clk) disable iff (!rstN)
		wbValid |-> !$isunknown(wbReg));

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module regFile (
	input  wire logic                    clk,
	input  wire logic                    rstN,
	input  wire logic [`PIPE_SEL_W-1:0]  rdSel1,
	input  wire logic [`PIPE_SEL_W-1:0]  rdSel2,
	output logic [`PIPE_DATA_W-1:0]      rdData1,
	output logic [`PIPE_DATA_W-1:0]      rdData2,
	input  wire logic                    wrEn,
	input  wire logic [`PIPE_SEL_W-1:0]  wrSel,
	input  wire logic [`PIPE_DATA_W-1:0] wrData
);

	logic [`PIPE_DATA_W-1:0] regs [`PIPE_REG_CNT];

	// Write lands at the edge, reads see it next cycle
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `PIPE_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrSel] <= wrData;
		end
	end

	assign rdData1 = regs[rdSel1];
	assign rdData2 = regs[rdSel2];

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module decodeStage (
	input  wire logic                    clk,
	input  wire logic                    rstN,
	input  wire logic                    idValid,
	input  wire pipePkg::instWord_t      idInst,
	output logic                         stall,
	output logic [`PIPE_SEL_W-1:0]       rdSel1,
	output logic [`PIPE_SEL_W-1:0]       rdSel2,
	input  wire logic [`PIPE_DATA_W-1:0] rdData1,
	input  wire logic [`PIPE_DATA_W-1:0] rdData2,
	decodeExecIf.source                  toExec,
	execWbIf.hazard                      fromExec
);

	pipePkg::aluOp_t         aluOpD;
	logic [`PIPE_SEL_W-1:0]  destD;
	logic [`PIPE_DATA_W-1:0] immD;
	logic [7:0]              imm8;
	logic                    wrEnD;
	logic                    useRs;
	logic                    useRt;
	logic                    bImm;
	logic                    exHot;
	logic                    rsHit;
	logic                    rtHit;

	assign imm8 = {idInst.i.rdI, idInst.i.imm5};

	always_comb begin
		aluOpD  = pipePkg::ALU_ADD;
		destD   = idInst.i.rdI;
		immD    = '0;
		wrEnD   = 1'b0;
		useRs   = 1'b0;
		useRt   = 1'b0;
		bImm    = 1'b1;
		case (idInst.r.opcode)
			pipePkg::OP_ADDI, pipePkg::OP_SUBI: begin
				aluOpD = (idInst.r.opcode == pipePkg::OP_ADDI) ?
					pipePkg::ALU_ADD : pipePkg::ALU_SUBR;
				immD   = {{(`PIPE_DATA_W-5){idInst.i.imm5[4]}}, idInst.i.imm5};
				wrEnD  = 1'b1;
				useRs  = 1'b1;
			end
			pipePkg::OP_XORI, pipePkg::OP_ANDNI: begin
				aluOpD = (idInst.r.opcode == pipePkg::OP_XORI) ?
					pipePkg::ALU_XOR : pipePkg::ALU_ANDN;
				immD   = {{(`PIPE_DATA_W-5){1'b0}}, idInst.i.imm5};
				wrEnD  = 1'b1;
				useRs  = 1'b1;
			end
			pipePkg::OP_LBI: begin
				aluOpD = pipePkg::ALU_PASSB;
				immD   = {{(`PIPE_DATA_W-8){imm8[7]}}, imm8};
				destD  = idInst.i.rs;
				wrEnD  = 1'b1;
			end
			pipePkg::OP_SLBI: begin
				// rs is both source and destination
				aluOpD = pipePkg::ALU_SHOR;
				immD   = {{(`PIPE_DATA_W-8){1'b0}}, imm8};
				destD  = idInst.i.rs;
				wrEnD  = 1'b1;
				useRs  = 1'b1;
			end
			pipePkg::OP_RRR: begin
				destD = idInst.r.rd;
				wrEnD = 1'b1;
				useRs = 1'b1;
				useRt = 1'b1;
				bImm  = 1'b0;
				case (idInst.r.funct)
					pipePkg::FN_ADD:  aluOpD = pipePkg::ALU_ADD;
					pipePkg::FN_SUB:  aluOpD = pipePkg::ALU_SUBR;
					pipePkg::FN_XOR:  aluOpD = pipePkg::ALU_XOR;
					default:          aluOpD = pipePkg::ALU_ANDN;
				endcase
			end
			pipePkg::OP_NOP: begin
				wrEnD = 1'b0;
			end
			default: begin
				// Unknown opcodes act as a NOP
				wrEnD = 1'b0;
			end
		endcase
	end

	assign rdSel1 = idInst.r.rs;
	assign rdSel2 = idInst.r.rt;

	// RAW check against both in-flight writes as the regfile has no bypass
	assign exHot = fromExec.exValid && fromExec.exRegWrite;
	assign rsHit = useRs && ((exHot && idInst.r.rs == fromExec.exDest) ||
		(fromExec.wbValid && idInst.r.rs == fromExec.wbDest));
	assign rtHit = useRt && ((exHot && idInst.r.rt == fromExec.exDest) ||
		(fromExec.wbValid && idInst.r.rt == fromExec.wbDest));
	assign stall = idValid && (rsHit || rtHit);

	// Bubble on stall
	always_ff @(posedge clk) begin
		if (!rstN) begin
			toExec.valid    <= 1'b0;
			toExec.regWrite <= 1'b0;
		end else begin
			toExec.valid    <= idValid && !stall;
			toExec.regWrite <= idValid && !stall && wrEnD;
		end
	end

	always_ff @(posedge clk) begin
		toExec.aluOp <= aluOpD;
		toExec.opA   <= rdData1;
		toExec.opB   <= bImm ? immD : rdData2;
		toExec.dest  <= destD;
	end

	// Writes come only from opcodes that name a destination
	noWriteOnUnknown: assert property (@(posedge clk) disable iff (!rstN)
		(toExec.valid && toExec.regWrite) |->
			$past(idInst.r.opcode) inside {pipePkg::OP_ADDI, pipePkg::OP_SUBI,
			pipePkg::OP_XORI, pipePkg::OP_ANDNI, pipePkg::OP_SLBI, pipePkg::OP_LBI,
			pipePkg::OP_RRR});

endmodule

`default_nettype wire

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module fetchStage (
	input  wire logic                    clk,
	input  wire logic                    rstN,
	input  wire logic                    inValid,
	output logic                         inReady,
	input  wire logic [`PIPE_DATA_W-1:0] inInst,
	input  wire logic                    stall,
	output logic                         idValid,
	output pipePkg::instWord_t           idInst
);

	logic               validQ;
	pipePkg::instWord_t instQ;

	// Room when empty or decode consumes the held word
	assign inReady = !validQ || !stall;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			validQ <= 1'b0;
		end else if (inReady) begin
			validQ <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inReady && inValid) begin
			instQ <= pipePkg::instWord_t'(inInst);
		end
	end

	assign idValid = validQ;
	assign idInst  = instQ;

	// Word must survive a decode stall
	holdOnStall: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> $stable(instQ));

endmodule

`default_nettype wire

// ==== verilog/stageIf.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

// Decode/execute pipeline register contents
interface decodeExecIf;
	logic                    valid;
	pipePkg::aluOp_t         aluOp;
	logic [`PIPE_DATA_W-1:0] opA;
	logic [`PIPE_DATA_W-1:0] opB;
	logic [`PIPE_SEL_W-1:0]  dest;
	logic                    regWrite;

	modport source (output valid, aluOp, opA, opB, dest, regWrite);
	modport sink (input valid, aluOp, opA, opB, dest, regWrite);
endinterface

// In-flight writes seen by the hazard check
interface execWbIf;
	logic                   exValid;
	logic [`PIPE_SEL_W-1:0] exDest;
	logic                   exRegWrite;
	logic                   wbValid;
	logic [`PIPE_SEL_W-1:0] wbDest;

	modport driver (output exValid, exDest, exRegWrite, wbValid, wbDest);
	modport hazard (input exValid, exDest, exRegWrite, wbValid, wbDest);
endinterface

`default_nettype wire

// ==== verilog/pipePkg.sv ====
`default_nettype none

`include "pipe_cfg.svh"

package pipePkg;

	// Major opcodes, instruction bits 15..11
	typedef enum logic [4:0] {
		OP_NOP   = 5'b00001,
		OP_ADDI  = 5'b01000,
		OP_SUBI  = 5'b01001,
		OP_XORI  = 5'b01010,
		OP_ANDNI = 5'b01011,
		OP_SLBI  = 5'b10010,
		OP_LBI   = 5'b11000,
		OP_RRR   = 5'b11011
	} opcode_t;

	// R-format function field
	typedef enum logic [1:0] {
		FN_ADD  = 2'b00,
		FN_SUB  = 2'b01,
		FN_XOR  = 2'b10,
		FN_ANDN = 2'b11
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUBR  = 3'd1, // B - A
		ALU_XOR   = 3'd2,
		ALU_ANDN  = 3'd3,
		ALU_PASSB = 3'd4,
		ALU_SHOR  = 3'd5  // (A << 8) | B
	} aluOp_t;

	typedef struct packed {
		opcode_t                opcode;
		logic [`PIPE_SEL_W-1:0] rs;
		logic [`PIPE_SEL_W-1:0] rt;
		logic [`PIPE_SEL_W-1:0] rd;
		funct_t                 funct;
	} rFmt_t;

	// imm8 forms take {rdI, imm5} as the byte
	typedef struct packed {
		opcode_t                opcode;
		logic [`PIPE_SEL_W-1:0] rs;
		logic [`PIPE_SEL_W-1:0] rdI;
		logic [4:0]             imm5;
	} iFmt_t;

	typedef union packed {
		rFmt_t r;
		iFmt_t i;
	} instWord_t;

endpackage

`default_nettype wire

// ==== verilog/pipe_cfg.svh ====
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// Data path and instruction word width
`define PIPE_DATA_W 16

// Architectural registers
`define PIPE_REG_CNT 8

// Register selector width
`define PIPE_SEL_W 3

`endif
